// File: common/cpu_mem_config.svh
// Build-time sizes of the CPU memory subsystem.
// Include wherever a cache, memory or latency size is needed.

`ifndef CPU_MEM_CONFIG_SVH
`define CPU_MEM_CONFIG_SVH

// Instruction cache index bits, 256 lines.
`define CPU_ICACHE_DEPTH_BITS 8

// Main memory word address bits, 4K words.
`define CPU_MEM_WORD_BITS 12

// Cycles from accepted request to ready pulse.
`define CPU_MEM_LATENCY 3

// Odd tag, never equal to an even fetch address.
`define CPU_ICACHE_INVALID_TAG 16'h0001

`endif

// File: common/cpu_mem_pkg.sv
// Types shared by the instruction cache, the memory arbiter and main memory.
// Import into a module header where the types are needed.

package cpu_mem_pkg;

	typedef logic [15:0] addr_t;      // CPU byte address.
	typedef logic [15:0] word_t;      // Instruction or data word.
	typedef logic [14:0] word_addr_t; // Byte address without bit 0.

	// Cache line, also the fetch result.
	typedef struct packed {
		addr_t tag;
		word_t instr;
	} icache_line_t;

	// One request to memory.
	typedef struct packed {
		logic       write;
		word_addr_t address;
		word_t      wdata;
	} mem_req_t;

	typedef enum logic [1:0] {
		state_idle,
		state_request_mem,
		state_grant_mem,
		state_settle
	} icache_state_t;

endpackage

// File: icache/bram.sv
// Simple dual-port block RAM with one write port and a registered read port.
// A read in the same cycle as a write to that line returns the old line.
// Every line powers up with the invalid tag so that it cannot hit.
`timescale 1ns/1ps
`include "cpu_mem_config.svh"

module bram #(
	parameter int BITS         = 32,
	parameter int ADDRESS_BITS = 8
) (
	input  logic                    CLK,
	input  logic [ADDRESS_BITS-1:0] rd_address,
	output logic [BITS-1:0]         data_out,
	input  logic [ADDRESS_BITS-1:0] wr_address,
	input  logic [BITS-1:0]         data_in,
	input  logic                    wr
);

	localparam int DEPTH = 1 << ADDRESS_BITS;
	localparam logic [BITS-1:0] FILL_LINE = {`CPU_ICACHE_INVALID_TAG, {(BITS - 16){1'b0}}};

	logic [BITS-1:0] ram [DEPTH];

	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			ram[i] = FILL_LINE; // Invalid tag, zero instruction.
		end
	end

	always_ff @(posedge CLK) begin
		if (wr) begin
			ram[wr_address] <= data_in;
		end
		data_out <= ram[rd_address];
	end

endmodule

// File: icache/cpu_instruction_cache.sv
// Direct-mapped instruction cache in front of the memory arbiter.
// address_data and cache_miss are valid one cycle after request_address.
// A miss refills one word; the fetch unit holds its address until the
// miss clears.
`timescale 1ns/1ps
`include "cpu_mem_config.svh"

module cpu_instruction_cache
	import cpu_mem_pkg::*;
(
	input  logic         CLK,
	input  logic         RSTb,
	input  addr_t        request_address,
	output icache_line_t address_data,
	output logic         cache_miss,
	output logic         memory_valid,
	input  logic         memory_ready,
	output word_addr_t   memory_address,
	input  word_t        memory_data
);

	localparam int INDEX_BITS = `CPU_ICACHE_DEPTH_BITS;

	icache_line_t  line_q;
	icache_line_t  wr_line;
	addr_t         request_q;
	addr_t         miss_address;
	icache_state_t state;
	logic          wr_bram;

	// ----------------------------------------
	// Line storage and tag compare
	// ----------------------------------------

	bram #(
		.BITS        ($bits(icache_line_t)),
		.ADDRESS_BITS(INDEX_BITS)
	) i_bram (
		.CLK       (CLK),
		.rd_address(request_address[INDEX_BITS:1]),
		.data_out  (line_q),
		.wr_address(miss_address[INDEX_BITS:1]),
		.data_in   (wr_line),
		.wr        (wr_bram)
	);

	always_ff @(posedge CLK) begin
		request_q <= request_address; // Aligns with the BRAM read.
	end

	assign address_data = line_q;
	assign cache_miss   = request_q != line_q.tag;

	// ----------------------------------------
	// Refill FSM
	// ----------------------------------------

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state        <= state_idle;
			memory_valid <= 1'b0;
		end else begin
			case (state)
				state_idle: begin
					if (cache_miss) begin
						memory_valid <= 1'b1;
						state        <= state_request_mem;
					end
				end
				state_request_mem: begin
					if (memory_ready) begin
						memory_valid <= 1'b0;
						state        <= state_grant_mem;
					end
				end
				state_grant_mem: begin
					state <= state_settle; // Line written this cycle.
				end
				state_settle: begin
					state <= state_idle; // Next read sees the new line.
				end
				default: begin
					state <= state_idle;
				end
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == state_idle && cache_miss) begin
			miss_address <= request_q;
		end
	end

	// Read word arrives the cycle after ready.
	assign wr_bram        = state == state_grant_mem;
	assign wr_line.tag    = miss_address;
	assign wr_line.instr  = memory_data;
	assign memory_address = miss_address[15:1];

	// Request held until the arbiter answers.
	a_valid_held: assert property (@(posedge CLK) disable iff (!RSTb)
		memory_valid && !memory_ready |=> memory_valid);

	// Fetch unit only presents even addresses.
	a_tag_written: assert property (@(posedge CLK) disable iff (!RSTb)
		wr_bram |-> wr_line.tag != `CPU_ICACHE_INVALID_TAG);

endmodule

// File: src/memory_arbiter.sv
// Shares single-ported main memory between the CPU data port and the
// instruction cache. Data port has fixed priority; a grant is taken at an
// idle edge and released on the edge after the memory's ready pulse.
`timescale 1ns/1ps

module memory_arbiter
	import cpu_mem_pkg::*;
(
	input  logic       CLK,
	input  logic       RSTb,
	input  logic       data_valid,
	input  mem_req_t   data_req,
	output logic       data_ready,
	input  logic       icache_valid,
	input  word_addr_t icache_address,
	output logic       icache_ready,
	output logic       mem_valid,
	output mem_req_t   mem_req,
	input  logic       mem_ready
);

	logic grant_data;
	logic grant_icache;
	logic idle;

	assign idle = !grant_data && !grant_icache;

	// ----------------------------------------
	// Grant owner
	// ----------------------------------------

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			grant_data   <= 1'b0;
			grant_icache <= 1'b0;
		end else if (idle) begin
			grant_data   <= data_valid;
			grant_icache <= icache_valid && !data_valid; // Data port first.
		end else if (mem_ready) begin
			grant_data   <= 1'b0;
			grant_icache <= 1'b0;
		end
	end

	// ----------------------------------------
	// Request mux and ready steering
	// ----------------------------------------

	assign mem_valid = (grant_data && data_valid) || (grant_icache && icache_valid);

	always_comb begin
		mem_req = data_req;
		if (grant_icache) begin
			mem_req.write   = 1'b0; // Fetches only read.
			mem_req.address = icache_address;
			mem_req.wdata   = '0;
		end
	end

	assign data_ready   = grant_data && mem_ready;
	assign icache_ready = grant_icache && mem_ready;

	// A ready pulse only reaches a requester that is still asking.
	a_ready_owner: assert property (@(posedge CLK) disable iff (!RSTb)
		(data_ready |-> data_valid) and (icache_ready |-> icache_valid)
		and !(data_ready && icache_ready));

	// Owner fixed while memory works on a request.
	a_grant_stable: assert property (@(posedge CLK) disable iff (!RSTb)
		mem_valid && !mem_ready |=> $stable({grant_data, grant_icache}));

endmodule

// File: src/main_memory.sv
// Word-addressed main memory behind the arbiter.
// Each accepted request is answered LATENCY cycles later with a one-cycle
// ready pulse; read data follows in the cycle after the pulse.
`timescale 1ns/1ps
`include "cpu_mem_config.svh"

module main_memory
	import cpu_mem_pkg::*;
#(
	parameter int LATENCY = `CPU_MEM_LATENCY
) (
	input  logic     CLK,
	input  logic     RSTb,
	input  logic     mem_valid,
	input  mem_req_t mem_req,
	output logic     mem_ready,
	output word_t    mem_rdata
);

	localparam int DEPTH    = 1 << `CPU_MEM_WORD_BITS;
	localparam int CNT_BITS = $clog2(LATENCY + 1);

	word_t                         mem [DEPTH];
	logic                          busy;
	logic [CNT_BITS-1:0]           count;
	logic [`CPU_MEM_WORD_BITS-1:0] index;

	assign index     = mem_req.address[`CPU_MEM_WORD_BITS-1:0]; // Low bits only.
	assign mem_ready = busy && count == '0;

	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	// Latency countdown.
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			busy  <= 1'b0;
			count <= '0;
		end else if (!busy) begin
			if (mem_valid) begin
				busy  <= 1'b1;
				count <= CNT_BITS'(LATENCY - 1);
			end
		end else if (count != '0) begin
			count <= count - 1'b1;
		end else begin
			busy <= 1'b0; // Ready cycle.
		end
	end

	always_ff @(posedge CLK) begin
		if (mem_ready) begin
			if (mem_req.write) begin
				mem[index] <= mem_req.wdata;
			end else begin
				mem_rdata <= mem[index];
			end
		end
	end

	a_req_stable: assert property (@(posedge CLK) disable iff (!RSTb)
		busy |-> mem_valid && $stable(mem_req));

endmodule

// File: src/cpu_mem_subsystem.sv
// Top of the CPU memory subsystem: instruction cache, memory arbiter and
// main memory. The CPU connects its fetch unit and load/store port here.
`timescale 1ns/1ps
`include "cpu_mem_config.svh"

module cpu_mem_subsystem
	import cpu_mem_pkg::*;
(
	input  logic         CLK,
	input  logic         RSTb,
	input  addr_t        fetch_address,
	output icache_line_t fetch_line,
	output logic         fetch_miss,
	input  logic         data_valid,
	input  mem_req_t     data_req,
	output logic         data_ready,
	output word_t        data_rdata
);

	logic       icache_valid;
	logic       icache_ready;
	word_addr_t icache_address;
	logic       mem_valid;
	logic       mem_ready;
	mem_req_t   mem_req;
	word_t      mem_rdata;

	cpu_instruction_cache i_icache (
		.CLK            (CLK),
		.RSTb           (RSTb),
		.request_address(fetch_address),
		.address_data   (fetch_line),
		.cache_miss     (fetch_miss),
		.memory_valid   (icache_valid),
		.memory_ready   (icache_ready),
		.memory_address (icache_address),
		.memory_data    (mem_rdata)
	);

	memory_arbiter i_arbiter (
		.CLK           (CLK),
		.RSTb          (RSTb),
		.data_valid    (data_valid),
		.data_req      (data_req),
		.data_ready    (data_ready),
		.icache_valid  (icache_valid),
		.icache_address(icache_address),
		.icache_ready  (icache_ready),
		.mem_valid     (mem_valid),
		.mem_req       (mem_req),
		.mem_ready     (mem_ready)
	);

	main_memory #(
		.LATENCY(`CPU_MEM_LATENCY)
	) i_memory (
		.CLK      (CLK),
		.RSTb     (RSTb),
		.mem_valid(mem_valid),
		.mem_req  (mem_req),
		.mem_ready(mem_ready),
		.mem_rdata(mem_rdata)
	);

	assign data_rdata = mem_rdata; // Shared with the cache refill.

endmodule

// File: sim/tb_cpu_mem_subsystem.sv
// Directed testbench for the CPU memory subsystem.
// Inputs change on the falling clock edge. Results are checked against a
// reference copy of the words written through the data port.
`timescale 1ns/1ps
`include "cpu_mem_config.svh"

module tb_cpu_mem_subsystem
	import cpu_mem_pkg::*;
#(
	parameter int unsigned SEED = 32'hb67e
);

	localparam int MEM_DEPTH        = 1 << `CPU_MEM_WORD_BITS;
	localparam int RESET_CYCLES     = 8;
	localparam int DATA_WORDS       = 32;
	localparam int READY_BOUND      = 2 + `CPU_MEM_LATENCY + 2; // Grant, accept, spare.
	localparam int REFILL_CYCLES    = 2 + 1 + `CPU_MEM_LATENCY + 1 + 1;
	localparam int FETCH_BOUND      = REFILL_CYCLES + 2; // Lookup cycle and a spare.
	localparam int CONTENTION_BOUND = READY_BOUND + FETCH_BOUND;
	// Up to 100 transactions of 20 cycles each, doubled.
	localparam int TIMEOUT_CYCLES   = 2 * 100 * 20;

	// Fetch addresses live in memory words 0x800 and up.
	localparam addr_t      BOOT_ADDR     = 16'h1F00;
	localparam addr_t      FETCH_A       = 16'h1234;
	localparam addr_t      FETCH_B       = 16'h1C66;
	localparam addr_t      CONFLICT_ADDR = 16'hB434; // Same line as FETCH_A.
	localparam addr_t      SHARED_ADDR   = 16'h1AAA;
	localparam word_addr_t DATA_MASK     = 15'h77FF; // Data words stay below 0x800.

	logic         CLK;
	logic         RSTb;
	addr_t        fetch_address;
	icache_line_t fetch_line;
	logic         fetch_miss;
	logic         data_valid;
	mem_req_t     data_req;
	logic         data_ready;
	word_t        data_rdata;

	word_t      ref_mem [MEM_DEPTH];
	word_addr_t written_addr [$];
	int         cycle_count = 0;

	cpu_mem_subsystem i_dut (
		.CLK          (CLK),
		.RSTb         (RSTb),
		.fetch_address(fetch_address),
		.fetch_line   (fetch_line),
		.fetch_miss   (fetch_miss),
		.data_valid   (data_valid),
		.data_req     (data_req),
		.data_ready   (data_ready),
		.data_rdata   (data_rdata)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES)
			abort_run("Timeout: the run went past its cycle limit.");
	end

	// ----------------------------------------
	// Checks and reference model
	// ----------------------------------------

	task automatic abort_run(string reason);
		$display("%s", reason);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Stopped at the first error.");
	endtask

	task automatic check_word(string name, word_t actual, word_t expected);
		if (actual !== expected)
			abort_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected));
	endtask

	task automatic check_line(string name, icache_line_t actual, icache_line_t expected);
		if (actual !== expected)
			abort_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected));
	endtask

	task automatic check_bit(string name, logic actual, logic expected);
		if (actual !== expected)
			abort_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected));
	endtask

	function automatic logic [`CPU_MEM_WORD_BITS-1:0] mem_index(word_addr_t waddr);
		return waddr[`CPU_MEM_WORD_BITS-1:0]; // Memory ignores upper bits.
	endfunction

	function automatic icache_line_t expected_line(addr_t address);
		icache_line_t line;
		line.tag   = address;
		line.instr = ref_mem[mem_index(address[15:1])];
		return line;
	endfunction

	// ----------------------------------------
	// Port drivers
	// ----------------------------------------

	task automatic wait_data_ready();
		int cycles;
		cycles = 0;
		while (data_ready !== 1'b1) begin
			if (cycles >= READY_BOUND)
				abort_run("Data port: no ready pulse within the memory latency.");
			@(negedge CLK);
			cycles++;
		end
	endtask

	task automatic data_write(word_addr_t waddr, word_t wdata);
		@(negedge CLK);
		data_valid = 1'b1;
		data_req   = '{write: 1'b1, address: waddr, wdata: wdata};
		wait_data_ready();
		@(negedge CLK); // Past the ready edge.
		data_valid = 1'b0;
		check_bit("data_ready", data_ready, 1'b0);
		ref_mem[mem_index(waddr)] = wdata;
	endtask

	task automatic data_read_check(word_addr_t waddr);
		@(negedge CLK);
		data_valid = 1'b1;
		data_req   = '{write: 1'b0, address: waddr, wdata: '0};
		wait_data_ready();
		@(negedge CLK);
		data_valid = 1'b0;
		check_bit("data_ready", data_ready, 1'b0);
		check_word("data_rdata", data_rdata, ref_mem[mem_index(waddr)]);
	endtask

	// Called one cycle after the address was presented, with a miss showing.
	task automatic wait_refill(addr_t address);
		int cycles;
		cycles = 1;
		while (fetch_miss !== 1'b0) begin
			if (cycles >= FETCH_BOUND)
				abort_run("Fetch: refill did not finish within the refill bound.");
			@(negedge CLK);
			check_bit("data_ready", data_ready, 1'b0);
			cycles++;
		end
		check_line("fetch_line", fetch_line, expected_line(address));
	endtask

	task automatic fetch_refill(addr_t address);
		@(negedge CLK);
		fetch_address = address;
		@(negedge CLK);
		check_bit("fetch_miss", fetch_miss, 1'b1);
		wait_refill(address);
	endtask

	task automatic fetch_hit(addr_t address);
		@(negedge CLK);
		fetch_address = address;
		@(negedge CLK);
		check_bit("fetch_miss", fetch_miss, 1'b0);
		check_line("fetch_line", fetch_line, expected_line(address));
	endtask

	// ----------------------------------------
	// Directed tests
	// ----------------------------------------

	task automatic test_reset_state();
		RSTb = 1'b0;
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(negedge CLK);
			if (i > 0)
				check_bit("fetch_miss", fetch_miss, 1'b1);
			check_bit("data_ready", data_ready, 1'b0);
			fetch_address = (i == RESET_CYCLES - 1) ? BOOT_ADDR : addr_t'($urandom) & 16'hFFFE;
		end
		@(negedge CLK);
		check_bit("fetch_miss", fetch_miss, 1'b1);
		RSTb = 1'b1;
		wait_refill(BOOT_ADDR); // Boot line fills with a zero word.
	endtask

	task automatic test_data_port();
		word_addr_t waddr;
		for (int i = 0; i < DATA_WORDS; i++) begin
			waddr = word_addr_t'($urandom) & DATA_MASK;
			data_write(waddr, word_t'($urandom));
			written_addr.push_back(waddr);
		end
		foreach (written_addr[i])
			data_read_check(written_addr[i]);
	endtask

	task automatic test_fetch_refill();
		data_write(FETCH_A[15:1], word_t'($urandom));
		fetch_refill(FETCH_A);
		data_write(FETCH_B[15:1], word_t'($urandom));
		fetch_refill(FETCH_B);
	endtask

	task automatic test_hit();
		fetch_hit(BOOT_ADDR);
		fetch_hit(FETCH_A);
		fetch_hit(FETCH_B);
		fetch_hit(FETCH_A);
	endtask

	task automatic test_conflict();
		data_write(CONFLICT_ADDR[15:1], word_t'($urandom));
		fetch_refill(CONFLICT_ADDR);
		fetch_refill(FETCH_A);  // Evicted line comes back.
		fetch_hit(FETCH_B);
	endtask

	task automatic test_contention();
		word_addr_t raddr;
		int         cycles;
		logic       ready_seen;
		logic       data_done;
		data_write(SHARED_ADDR[15:1], word_t'($urandom));
		raddr = written_addr[DATA_WORDS / 2];
		@(negedge CLK);
		fetch_address = SHARED_ADDR;
		ready_seen    = 1'b0;
		data_done     = 1'b0;
		@(negedge CLK);
		check_bit("fetch_miss", fetch_miss, 1'b1);
		@(negedge CLK); // Refill request went up at the last edge.
		cycles     = 2;
		data_valid = 1'b1; // Both requests meet at the next idle edge.
		data_req   = '{write: 1'b0, address: raddr, wdata: '0};
		while (fetch_miss !== 1'b0) begin
			if (cycles >= CONTENTION_BOUND)
				abort_run("Contention: fetch refill did not finish in time.");
			@(negedge CLK);
			cycles++;
			if (data_done) begin
				check_bit("data_ready", data_ready, 1'b0);
			end else if (ready_seen) begin
				data_valid = 1'b0;
				check_word("data_rdata", data_rdata, ref_mem[mem_index(raddr)]);
				data_done = 1'b1;
			end else if (data_ready === 1'b1) begin
				ready_seen = 1'b1;
			end
		end
		if (!data_done)
			abort_run("Contention: fetch refill finished before the data read.");
		check_line("fetch_line", fetch_line, expected_line(SHARED_ADDR));
	endtask

	initial begin
		void'($urandom(SEED));
		RSTb          = 1'b0;
		fetch_address = BOOT_ADDR;
		data_valid    = 1'b0;
		data_req      = '0;
		foreach (ref_mem[i])
			ref_mem[i] = '0; // Main memory powers up cleared.

		test_reset_state();
		test_data_port();
		test_fetch_refill();
		test_hit();
		test_conflict();
		test_contention();

		@(negedge CLK);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: sources.f
+incdir+common
common/cpu_mem_pkg.sv
icache/bram.sv
icache/cpu_instruction_cache.sv
src/memory_arbiter.sv
src/main_memory.sv
src/cpu_mem_subsystem.sv
sim/tb_cpu_mem_subsystem.sv

// File: Makefile
# Verilator build and run of the CPU memory subsystem testbench.
VERILATOR ?= verilator
TOP       ?= tb_cpu_mem_subsystem
SEED      ?= 46718
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

FILELIST := sources.f
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)
SIM_BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# The binary is rebuilt only when a source or the file list changes.
$(OBJ_DIR)/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $* -GSEED=$(SEED) \
		--Mdir $(OBJ_DIR) -o V$*

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
